//--- build.f
source/mvu_pkg.sv
source/mvu_job_ctrl.sv
source/mvu_ctrl_delay.sv
source/mvu_dot_core.sv
source/mvu_top.sv
sim/tb_mvu_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_mvu_top -o sim_tb_mvu_top

out=$(./obj_dir/sim_tb_mvu_top)
echo "$out"

if echo "$out" | grep -q "^Test passed$"; then
    exit 0
fi
exit 1

//--- sim/tb_mvu_top.sv
// Testbench for mvu_top: loads random memories, runs directed and random jobs, checks results
`default_nettype none

module tb_mvu_top;

    timeunit 1ns;
    timeprecision 100ps;

    import mvu_pkg::*;

    localparam int N_RAND = 6;      // Random back-to-back jobs
    localparam int MAX_CD = 32;     // Largest random countdown
    localparam int N_TESTS = 5;
    // Reset, memory loads, directed countdowns, random countdowns, slack per test
    localparam int WATCHDOG_CYCLES = 16 + (1 + N_RAND) * 64 + 12 + 8 + 10
                                     + N_RAND * MAX_CD + N_TESTS * 50;

    logic     mvu_ext;
    logic     reset;
    logic     start;
    mvu_cfg_t cfg;
    logic     wrw_en;
    addr_t    wrw_addr;
    word_t    wrw_word;
    logic     wrd_en;
    addr_t    wrd_addr;
    word_t    wrd_word;
    logic     done;
    logic     irq;
    logic     result_valid;
    sum_t     result;

    word_t       wmem_ref [2**ADDR_W];   // Copy of the weight memory
    word_t       dmem_ref [2**ADDR_W];
    sum_t        exp_q [$];              // Expected results in order
    sum_t        exp_sum;
    logic [31:0] lcg_state = 32'h6e0a;
    logic        started = 1'b0;
    logic        irq_d1 = 1'b0;
    logic        irq_d2 = 1'b0;
    int          err_assert = 0;         // Counted by the concurrent assertions
    int          err_check = 0;          // Counted by the result monitor
    int          err_proc = 0;           // Counted by the test sequence
    int          irq_count = 0;
    int          results_seen = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    mvu_top DUT (
        .mvu_ext      (mvu_ext),
        .reset        (reset),
        .start        (start),
        .cfg          (cfg),
        .wrw_en       (wrw_en),
        .wrw_addr     (wrw_addr),
        .wrw_word     (wrw_word),
        .wrd_en       (wrd_en),
        .wrd_addr     (wrd_addr),
        .wrd_word     (wrd_word),
        .done         (done),
        .irq          (irq),
        .result_valid (result_valid),
        .result       (result)
    );

    always #4 mvu_ext = ~mvu_ext;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int total_errors();
        return err_assert + err_check + err_proc;
    endfunction

    function automatic mvu_cfg_t make_cfg(input cnt_t cd, input addr_t ib, input addr_t wb,
                                          input addr_t ij0, input addr_t ij1, input addr_t wj0,
                                          input addr_t wj1, input len_t il, input len_t wl);
        mvu_cfg_t c;
        c.countdown = cd;
        c.ibaseaddr = ib;
        c.wbaseaddr = wb;
        c.ijump0    = ij0;
        c.ijump1    = ij1;
        c.wjump0    = wj0;
        c.wjump1    = wj1;
        c.ilength   = il;
        c.wlength   = wl;
        return c;
    endfunction

    function automatic mvu_cfg_t rand_cfg();
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = lcg_next();
        r1 = lcg_next();
        return make_cfg(cnt_t'(r0[31:27]) + cnt_t'(1), r0[26:21], r0[20:15], r0[14:9],
                        r0[8:3], r1[31:26], r1[25:20], r1[19:16], r1[15:12]);
    endfunction

    task automatic tick();
        @(posedge mvu_ext);
        #1;
    endtask

    // Rewrites every word of both memories through the write ports
    task automatic load_memories();
        logic [31:0] r;
        for (int a = 0; a < 2**ADDR_W; a++) begin
            r = lcg_next();
            wrw_en   = 1'b1;
            wrw_addr = addr_t'(a);
            wrw_word = r[31:16];
            wrd_en   = 1'b1;
            wrd_addr = addr_t'(a);
            wrd_word = r[15:0] ^ r[31:16];
            wmem_ref[a] = r[31:16];
            dmem_ref[a] = r[15:0] ^ r[31:16];
            tick();
        end
        wrw_en = 1'b0;
        wrd_en = 1'b0;
    endtask

    // Walks both address generators and queues one sum per group end
    task automatic model_job(input mvu_cfg_t c);
        addr_t ia;
        addr_t wa;
        len_t  ic;
        len_t  wc;
        int    s;
        ia = c.ibaseaddr;
        wa = c.wbaseaddr;
        ic = '0;
        wc = '0;
        s  = 0;   // Running sum restarts only at the job's first read
        for (int k = 0; k < int'(c.countdown); k++) begin
            s = s + $countones(wmem_ref[wa] & dmem_ref[ia]);
            if ((wc == c.wlength) || (k == int'(c.countdown) - 1)) begin
                exp_q.push_back(sum_t'(s));
            end
            if (ic == c.ilength) begin
                ia = ia + c.ijump1;
                ic = '0;
            end else begin
                ia = ia + c.ijump0;
                ic = ic + len_t'(1);
            end
            if (wc == c.wlength) begin
                wa = wa + c.wjump1;
                wc = '0;
            end else begin
                wa = wa + c.wjump0;
                wc = wc + len_t'(1);
            end
        end
    endtask

    task automatic start_job(input mvu_cfg_t c);
        model_job(c);
        cfg     = c;
        start   = 1'b1;
        started = 1'b1;
        tick();
        start = 1'b0;
    endtask

    task automatic wait_irq(input int limit);
        int n;
        n = 0;
        while (irq !== 1'b1 && n < limit) begin
            tick();
            n++;
        end
        irq_in_time: assert (n < limit) else begin
            $display("No irq within %0d cycles at %0t", limit, $time);
            err_proc++;
        end
        repeat (3) tick();   // Last result and queue check land here
    endtask

    task automatic expect_count(input string what, input int got, input int want);
        count_ok: assert (got == want) else begin
            $display("Mismatch at %0t: %s expected %0d actual %0d", $time, what, want, got);
            err_proc++;
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests_run++;
        if (total_errors() == err_start) begin
            $display("%-24s ok", name);
        end else begin
            tests_failed++;
            $display("%-24s %0d errors", name, total_errors() - err_start);
        end
    endtask

    // Result monitor, sampled away from the rising edge
    always @(negedge mvu_ext) begin
        if (!reset && result_valid) begin
            results_seen++;
            result_expected: assert (exp_q.size() > 0) else begin
                $display("result_valid pulsed at %0t with no result expected", $time);
                err_check++;
            end
            if (exp_q.size() > 0) begin
                exp_sum = exp_q.pop_front();
                result_value: assert (result == exp_sum) else begin
                    $display("Mismatch at %0t: result expected %0d actual %0d",
                             $time, exp_sum, result);
                    err_check++;
                end
            end
        end
        if (!reset && irq_d2) begin
            queue_drained: assert (exp_q.size() == 0) else begin
                $display("%0d results still missing two cycles after irq at %0t",
                         exp_q.size(), $time);
                err_check++;
            end
        end
        if (!reset && irq) begin
            irq_count++;
        end
        irq_d2 = irq_d1;
        irq_d1 = irq;
    end

    quiet_before_start: assert property (@(posedge mvu_ext) disable iff (reset)
        !started |-> !(done || irq || result_valid))
        else begin
            $display("Output active before the first start at %0t", $time);
            err_assert++;
        end

    irq_single: assert property (@(posedge mvu_ext) disable iff (reset) irq |=> !irq)
        else begin
            $display("irq high for two cycles at %0t", $time);
            err_assert++;
        end

    done_with_irq: assert property (@(posedge mvu_ext) disable iff (reset)
        $rose(done) |-> irq)
        else begin
            $display("done rose without irq at %0t", $time);
            err_assert++;
        end

    done_held: assert property (@(posedge mvu_ext) disable iff (reset)
        done && !start |=> done)
        else begin
            $display("done fell without a start at %0t", $time);
            err_assert++;
        end

    done_cleared: assert property (@(posedge mvu_ext) disable iff (reset)
        done && start |=> !done)
        else begin
            $display("done not cleared by an accepted start at %0t", $time);
            err_assert++;
        end

    initial begin
        #(WATCHDOG_CYCLES * 8);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        int e0;
        int res0;
        int irq0;
        mvu_ext  = 1'b0;
        reset    = 1'b1;
        start    = 1'b0;
        cfg      = '0;
        wrw_en   = 1'b0;
        wrw_addr = '0;
        wrw_word = '0;
        wrd_en   = 1'b0;
        wrd_addr = '0;
        wrd_word = '0;
        repeat (16) tick();
        reset = 1'b0;

        e0 = total_errors();
        load_memories();   // Outputs must stay quiet throughout
        repeat (8) tick();
        finish_test("reset_quiet", e0);

        // Weight walk 62, 63, 0, 1 wraps around the top of memory
        e0   = total_errors();
        res0 = results_seen;
        start_job(make_cfg(8'd12, 6'd60, 6'd62, 6'd2, 6'd7, 6'd1, 6'd3, 4'd2, 4'd3));
        wait_irq(12 + 10);
        expect_count("results of jump job", results_seen - res0, 3);
        finish_test("jumps_and_wrap", e0);

        e0   = total_errors();
        res0 = results_seen;
        irq0 = irq_count;
        start_job(make_cfg(8'd8, 6'd5, 6'd9, 6'd1, 6'd1, 6'd2, 6'd2, 4'd7, 4'd7));
        repeat (3) tick();
        cfg   = make_cfg(8'd20, 6'd0, 6'd0, 6'd1, 6'd1, 6'd1, 6'd1, 4'd0, 4'd0);
        start = 1'b1;   // Arrives during RUN and must be dropped
        tick();
        start = 1'b0;
        wait_irq(8 + 10);
        repeat (12) tick();
        expect_count("irq pulses", irq_count - irq0, 1);
        expect_count("results of single group job", results_seen - res0, 1);
        expect_count("done level", int'(done), 1);
        finish_test("irq_done_and_busy_start", e0);

        // Groups of 4, 4 and a partial 2
        e0   = total_errors();
        res0 = results_seen;
        start_job(make_cfg(8'd10, 6'd33, 6'd17, 6'd5, 6'd11, 6'd3, 6'd9, 4'd1, 4'd3));
        wait_irq(10 + 10);
        expect_count("results of partial job", results_seen - res0, 3);
        finish_test("partial_last_group", e0);

        e0 = total_errors();
        for (int j = 0; j < N_RAND; j++) begin
            load_memories();
            start_job(rand_cfg());
            wait_irq(MAX_CD + 10);
        end
        finish_test("random_jobs", e0);

        $display("Tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/mvu_top.sv
// Top level of the binary dot-product slice, joins the job controller, control delay and core
`default_nettype none

module mvu_top (
    input  logic              mvu_ext,
    input  logic              reset,
    input  logic              start,
    input  mvu_pkg::mvu_cfg_t cfg,
    input  logic              wrw_en,
    input  mvu_pkg::addr_t    wrw_addr,
    input  mvu_pkg::word_t    wrw_word,
    input  logic              wrd_en,
    input  mvu_pkg::addr_t    wrd_addr,
    input  mvu_pkg::word_t    wrd_word,
    output logic              done,
    output logic              irq,
    output logic              result_valid,
    output mvu_pkg::sum_t     result
);

    import mvu_pkg::*;

    mvu_rd_t       rd;         // Read addresses and flags, same cycle
    mvu_acc_ctrl_t acc_ctrl;   // Flags after the read latency

    mvu_job_ctrl u_job_ctrl (
        .mvu_ext (mvu_ext),
        .reset   (reset),
        .start   (start),
        .cfg     (cfg),
        .rd      (rd),
        .done    (done),
        .irq     (irq)
    );

    mvu_ctrl_delay u_ctrl_delay (
        .mvu_ext  (mvu_ext),
        .reset    (reset),
        .rd       (rd),
        .acc_ctrl (acc_ctrl)
    );

    mvu_dot_core u_dot_core (
        .mvu_ext      (mvu_ext),
        .reset        (reset),
        .rd           (rd),
        .acc_ctrl     (acc_ctrl),
        .wrw_en       (wrw_en),
        .wrw_addr     (wrw_addr),
        .wrw_word     (wrw_word),
        .wrd_en       (wrd_en),
        .wrd_addr     (wrd_addr),
        .wrd_word     (wrd_word),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

//--- source/mvu_dot_core.sv
// Compute core with the weight and data memories, the AND and population count, and the group accumulator
`default_nettype none

module mvu_dot_core (
    input  logic                   mvu_ext,
    input  logic                   reset,
    input  mvu_pkg::mvu_rd_t       rd,
    input  mvu_pkg::mvu_acc_ctrl_t acc_ctrl,
    input  logic                   wrw_en,
    input  mvu_pkg::addr_t         wrw_addr,
    input  mvu_pkg::word_t         wrw_word,
    input  logic                   wrd_en,
    input  mvu_pkg::addr_t         wrd_addr,
    input  mvu_pkg::word_t         wrd_word,
    output logic                   result_valid,
    output mvu_pkg::sum_t          result
);

    import mvu_pkg::*;

    word_t wmem [2**ADDR_W];   // Weight memory
    word_t dmem [2**ADDR_W];   // Data memory
    word_t wword_q;
    word_t iword_q;
    sum_t  pop;
    sum_t  sum_next;
    sum_t  sum_q;
    logic  emit;

    // Number of lanes where both bits are one
    function automatic sum_t popcount(input word_t w);
        sum_t n;
        n = '0;
        for (int b = 0; b < LANES; b++) begin
            n = n + sum_t'(w[b]);
        end
        return n;
    endfunction

    always_ff @(posedge mvu_ext) begin
        if (wrw_en) begin
            wmem[wrw_addr] <= wrw_word;
        end
        if (rd.rd_en) begin
            wword_q <= wmem[rd.waddr];   // Old word on a same-address write
        end
    end

    always_ff @(posedge mvu_ext) begin
        if (wrd_en) begin
            dmem[wrd_addr] <= wrd_word;
        end
        if (rd.rd_en) begin
            iword_q <= dmem[rd.iaddr];
        end
    end

    assign pop      = popcount(wword_q & iword_q);
    assign sum_next = acc_ctrl.first ? pop : sum_q + pop;   // First read restarts the sum
    assign emit     = acc_ctrl.acc && acc_ctrl.group_end;

    always_ff @(posedge mvu_ext) begin
        if (acc_ctrl.acc) begin
            sum_q <= sum_next;
        end
        if (emit) begin
            result <= sum_next;   // Includes the group's last word
        end
    end

    // Valid pulse in step with the result register
    always_ff @(posedge mvu_ext) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= emit;
        end
    end

    // A result trails the group's last read by the read latency plus one
    a_valid_after_group_end: assert property (@(posedge mvu_ext) disable iff (reset)
        result_valid |-> $past(rd.group_end, MEM_RD_LATENCY + 1));

endmodule

`default_nettype wire

//--- source/mvu_ctrl_delay.sv
// Control delay line: re-times the read controls to the memory read latency for the accumulator
`default_nettype none

module mvu_ctrl_delay (
    input  logic                   mvu_ext,
    input  logic                   reset,
    input  mvu_pkg::mvu_rd_t       rd,
    output mvu_pkg::mvu_acc_ctrl_t acc_ctrl
);

    import mvu_pkg::*;

    mvu_acc_ctrl_t stage_in;
    mvu_acc_ctrl_t pipe_q [MEM_RD_LATENCY];   // One stage per read cycle

    always_comb begin
        stage_in.acc       = rd.rd_en;
        stage_in.first     = rd.first;
        stage_in.group_end = rd.group_end;
    end

    always_ff @(posedge mvu_ext) begin
        if (reset) begin
            for (int s = 0; s < MEM_RD_LATENCY; s++) begin
                pipe_q[s] <= '0;
            end
        end else begin
            pipe_q[0] <= stage_in;
            for (int s = 1; s < MEM_RD_LATENCY; s++) begin
                pipe_q[s] <= pipe_q[s-1];
            end
        end
    end

    assign acc_ctrl = pipe_q[MEM_RD_LATENCY-1];   // Lines up with the read words

    // The producer only marks first on a real read
    a_first_with_acc: assert property (@(posedge mvu_ext) disable iff (reset)
        acc_ctrl.first |-> acc_ctrl.acc);

endmodule

`default_nettype wire

//--- source/mvu_job_ctrl.sv
// Job controller that latches the configuration on start, runs the countdown and walks both memory addresses
`default_nettype none

module mvu_job_ctrl (
    input  logic              mvu_ext,
    input  logic              reset,
    input  logic              start,
    input  mvu_pkg::mvu_cfg_t cfg,
    output mvu_pkg::mvu_rd_t  rd,
    output logic              done,
    output logic              irq
);

    import mvu_pkg::*;

    mvu_cfg_t    cfg_q;      // Configuration of the current job
    ctrl_state_t state_q;
    cnt_t        cnt_q;      // Run cycles left, this one included
    logic        first_q;
    addr_t       iaddr_q;
    addr_t       waddr_q;
    len_t        icnt_q;     // Inner position of the data generator
    len_t        wcnt_q;     // Inner position of the weight generator
    logic        start_ok;
    logic        running;
    logic        run_last;
    logic        i_wrap;
    logic        w_wrap;

    assign start_ok = start && (state_q == IDLE);    // Start outside IDLE is dropped
    assign running  = (state_q == RUN);
    assign run_last = running && (cnt_q <= cnt_t'(1));
    assign i_wrap   = (icnt_q == cfg_q.ilength);     // Outer jump due on this read
    assign w_wrap   = (wcnt_q == cfg_q.wlength);

    always_ff @(posedge mvu_ext) begin
        if (reset) begin
            cfg_q <= '0;
        end else if (start_ok) begin
            cfg_q <= cfg;
        end
    end

    // Countdown FSM with ARMED as the delayed start
    always_ff @(posedge mvu_ext) begin
        if (reset) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            first_q <= 1'b0;
            done    <= 1'b0;
            irq     <= 1'b0;
        end else begin
            irq <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_ok) begin
                        state_q <= ARMED;
                        done    <= 1'b0;   // Cleared by the accepted start
                    end
                end
                ARMED: begin
                    state_q <= RUN;
                    cnt_q   <= cfg_q.countdown;
                    first_q <= 1'b1;
                end
                RUN: begin
                    first_q <= 1'b0;
                    cnt_q   <= cnt_q - cnt_t'(1);
                    if (run_last) begin
                        state_q <= IDLE;
                        done    <= 1'b1;   // Held until the next start
                        irq     <= 1'b1;   // Single cycle
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Data and weight address generators share the two-jump rule
    always_ff @(posedge mvu_ext) begin
        if (reset) begin
            iaddr_q <= '0;
            waddr_q <= '0;
            icnt_q  <= '0;
            wcnt_q  <= '0;
        end else if (state_q == ARMED) begin
            iaddr_q <= cfg_q.ibaseaddr;
            waddr_q <= cfg_q.wbaseaddr;
            icnt_q  <= '0;
            wcnt_q  <= '0;
        end else if (running) begin
            iaddr_q <= iaddr_q + (i_wrap ? cfg_q.ijump1 : cfg_q.ijump0);  // Wraps at 64
            waddr_q <= waddr_q + (w_wrap ? cfg_q.wjump1 : cfg_q.wjump0);
            icnt_q  <= i_wrap ? len_t'(0) : icnt_q + len_t'(1);
            wcnt_q  <= w_wrap ? len_t'(0) : wcnt_q + len_t'(1);
        end
    end

    always_comb begin
        rd.iaddr     = iaddr_q;
        rd.waddr     = waddr_q;
        rd.rd_en     = running;
        rd.first     = running && first_q;
        rd.group_end = running && (w_wrap || run_last);  // Partial group closes at the end
    end

    // Every read uses up one programmed run cycle
    a_rd_in_countdown: assert property (@(posedge mvu_ext) disable iff (reset)
        rd.rd_en |-> (cnt_q != '0));

    a_irq_pulse: assert property (@(posedge mvu_ext) disable iff (reset)
        irq |=> !irq);

endmodule

`default_nettype wire

//--- source/mvu_pkg.sv
// Shared widths, types and control structs of the binary dot-product slice, compiled before the RTL
`default_nettype none

package mvu_pkg;

    localparam int LANES          = 16;  // One-bit lanes per memory word
    localparam int ADDR_W         = 6;   // 64 words per memory
    localparam int LEN_W          = 4;
    localparam int CNT_W          = 8;
    localparam int SUM_W          = 12;  // Holds 255 full words of 16 ones
    localparam int MEM_RD_LATENCY = 1;   // Same for both memories

    typedef logic [LANES-1:0]  word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  len_t;    // Actual length minus one
    typedef logic [CNT_W-1:0]  cnt_t;
    typedef logic [SUM_W-1:0]  sum_t;

    // Job configuration, captured on start
    typedef struct packed {
        cnt_t  countdown;   // Run cycles, at least 1
        addr_t ibaseaddr;
        addr_t wbaseaddr;
        addr_t ijump0;      // Inner step
        addr_t ijump1;      // Outer step
        addr_t wjump0;
        addr_t wjump1;
        len_t  ilength;
        len_t  wlength;
    } mvu_cfg_t;

    typedef struct packed {
        addr_t iaddr;
        addr_t waddr;
        logic  rd_en;
        logic  first;       // First read of the job
        logic  group_end;   // Weight outer jump or last run cycle
    } mvu_rd_t;

    // Accumulator controls, aligned with the memory read data
    typedef struct packed {
        logic acc;
        logic first;
        logic group_end;
    } mvu_acc_ctrl_t;

    typedef enum logic [1:0] {
        IDLE,
        ARMED,
        RUN
    } ctrl_state_t;

endpackage

`default_nettype wire
